/* include/fp_rnd_model.svh */
// reference model of the rounding back end for one input item
`ifndef FP_RND_MODEL_SVH
`define FP_RND_MODEL_SVH

// adder items pass shr_req 0 and multiplier items pass sub_0 0
function automatic void fp_rnd_model(
  input  logic                            sign_in,
  input  logic                            sub_0,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]  fract,
  input  logic [fp_rnd_pkg::SH_W-1:0]     shr_req,
  input  logic [fp_rnd_pkg::SH_W-1:0]     shl,
  input  logic [fp_rnd_pkg::EXP_W-1:0]    exp_shr,
  input  logic [fp_rnd_pkg::EXP_W-1:0]    exp_shl,
  input  logic [fp_rnd_pkg::EXP_W-1:0]    exp_sh0,
  input  logic                            inv,
  input  logic                            inf,
  input  logic                            snan,
  input  logic                            qnan,
  input  logic                            nan_sign,
  input  logic [fp_rnd_pkg::RM_W-1:0]     rmode,
  input  logic [fp_rnd_pkg::FLAG_W-1:0]   mask,
  input  logic                            except_en,
  output logic [fp_rnd_pkg::FP32_W-1:0]   res,
  output logic [fp_rnd_pkg::FLAG_W-1:0]   flags,
  output logic                            exc
);
  logic                           sign;
  logic                           carry;
  int                             shr;
  logic [fp_rnd_pkg::EXP_W-1:0]   exp;
  logic [fp_rnd_pkg::FRACT_W-1:0] sh;
  logic                           rbit;
  logic                           sbit;
  logic                           lost;
  logic                           up;
  logic [24:0]                    m;
  fp_rnd_pkg::fp32_word_u         w;

  sign  = sub_0 ? (rmode == fp_rnd_pkg::RM_TO_INFM) : sign_in;
  carry = fract[fp_rnd_pkg::FRACT_W-1];
  shr   = (shr_req != 0) ? int'(shr_req) : int'(carry);
  exp   = (shr_req != 0) ? exp_shr : (shl == 0) ? exp_sh0 + 10'(carry) : exp_shl;
  sh    = (shr != 0) ? (fract >> shr) : (fract << shl);
  rbit  = sh[2];
  // low mask over bits 0 .. shr+1
  if (shr != 0)
    sbit = |(fract & ~({fp_rnd_pkg::FRACT_W{1'b1}} << (shr + 2)));
  else
    sbit = (shl == 0) ? |fract[1:0] : (shl == 1) ? fract[0] : 1'b0;
  lost = rbit | sbit;
  up   = ((rmode == fp_rnd_pkg::RM_NEAREST) &&
          ((rbit && sbit) || (sh[3] && rbit && !sbit))) ||
         ((rmode == fp_rnd_pkg::RM_TO_INFP) && !sign && lost) ||
         ((rmode == fp_rnd_pkg::RM_TO_INFM) && sign && lost);
  m    = sh[27:3] + 25'(up);
  if (m[24]) begin
    m   = m >> 1;
    exp = exp + 10'd1;
  end
  flags = '0;
  w.raw = {sign, 8'd0, m[22:0]};
  if (snan || qnan) begin
    w.raw = {nan_sign, fp_rnd_pkg::QNAN_BITS};
  end else if (inv) begin
    w.raw = {sign, fp_rnd_pkg::SNAN_BITS};
  end else if (exp > fp_rnd_pkg::EXP_MAX_FINITE || inf) begin
    w.raw                           = {sign, fp_rnd_pkg::INF_BITS};
    flags[fp_rnd_pkg::FLG_INF]      = 1'b1;
    flags[fp_rnd_pkg::FLG_OVF]      = !inf;
    flags[fp_rnd_pkg::FLG_INEXACT]  = lost || !inf;
  end else if (!m[23]) begin
    flags[fp_rnd_pkg::FLG_UNF]      = lost;
    flags[fp_rnd_pkg::FLG_ZERO]     = (m[23:0] == 0);
    flags[fp_rnd_pkg::FLG_INEXACT]  = lost;
  end else begin
    w.f.exp                         = exp[7:0];
    flags[fp_rnd_pkg::FLG_INEXACT]  = lost;
  end
  flags[fp_rnd_pkg::FLG_SNAN]    = inv;
  flags[fp_rnd_pkg::FLG_QNAN]    = qnan;
  flags[fp_rnd_pkg::FLG_INVALID] = inv | snan;
  flags = flags & mask;
  exc   = except_en & (|flags);
  res   = w.raw;
endfunction

`endif

/* bench/tb_fp32_rnd.sv */
// testbench for the fp32 rounding back end with stimulus, reference queue and output checks
`timescale 1ns/1ps

module tb_fp32_rnd;

  `include "fp_rnd_model.svh"

  logic        clk;
  logic        rst;
  logic        add_valid_i;
  logic        add_sign_i;
  logic        add_sub_0_i;
  logic [27:0] add_fract_i;
  logic [4:0]  add_shl_i;
  logic [9:0]  add_exp_shl_i;
  logic [9:0]  add_exp_sh0_i;
  logic        add_inv_i;
  logic        add_inf_i;
  logic        add_snan_i;
  logic        add_qnan_i;
  logic        add_nan_sign_i;
  logic        mul_valid_i;
  logic        mul_sign_i;
  logic [27:0] mul_fract_i;
  logic        mul_shl_i;
  logic [4:0]  mul_shr_i;
  logic [9:0]  mul_exp_shr_i;
  logic [9:0]  mul_exp_shl_i;
  logic [9:0]  mul_exp_sh0_i;
  logic        mul_inv_i;
  logic        mul_inf_i;
  logic        mul_snan_i;
  logic        mul_qnan_i;
  logic        mul_nan_sign_i;
  logic [1:0]  rmode_i;
  logic [7:0]  mask_i;
  logic        except_en_i;
  logic [31:0] res_o;
  logic [7:0]  flags_o;
  logic        except_o;
  logic        valid_o;

  logic [31:0] lfsr;
  logic [1:0]  stb_pipe = 2'b00;  // strobe history of the two stages
  logic [31:0] res_q[$];          // expected results in issue order
  logic [7:0]  flags_q[$];
  logic        exc_q[$];
  logic [31:0] e_res;
  logic [7:0]  e_flags;
  logic        e_exc;
  int          n_checks = 0;
  int          n_value_err = 0;
  int          n_valid_err = 0;
  int          n_reset_err = 0;
  int          n_timeout = 0;

  fp32_rnd uut (.*);

  //////////////////////////////////////////////////
  // clock, strobe history, random bits

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst)
      stb_pipe <= 2'b00;
    else
      stb_pipe <= {stb_pipe[0], add_valid_i | mul_valid_i};
  end

  // one galois step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // output checks sampled mid cycle

  always @(negedge clk) begin
    if (!rst) begin
      chk_valid: assert (valid_o == stb_pipe[1]) else begin
        n_valid_err++;
        $display("[FAIL] %0t valid_o is %b, expected %b", $time, valid_o, stb_pipe[1]);
      end
      if (valid_o) begin
        chk_pending: assert (res_q.size() != 0) else begin
          n_valid_err++;
          $display("valid_o rose at %0t with no result outstanding", $time);
        end
      end
      if (valid_o && res_q.size() != 0) begin
        e_res   = res_q.pop_front();
        e_flags = flags_q.pop_front();
        e_exc   = exc_q.pop_front();
        n_checks++;
        chk_res: assert (res_o == e_res) else begin
          n_value_err++;
          $display("[FAIL] %0t res_o %h, expected %h", $time, res_o, e_res);
        end
        chk_flags: assert (flags_o == e_flags) else begin
          n_value_err++;
          $display("[FAIL] %0t flags_o %b, expected %b", $time, flags_o, e_flags);
        end
        chk_exc: assert (except_o == e_exc) else begin
          n_value_err++;
          $display("[FAIL] %0t except_o %b, expected %b", $time, except_o, e_exc);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers

  task automatic clear_fields();
    {add_sign_i, add_sub_0_i, add_fract_i, add_shl_i, add_exp_shl_i, add_exp_sh0_i,
     add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_nan_sign_i} = '0;
    {mul_sign_i, mul_fract_i, mul_shl_i, mul_shr_i, mul_exp_shr_i, mul_exp_shl_i,
     mul_exp_sh0_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_nan_sign_i} = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // expected value goes in before the strobe
  task automatic issue_add();
    logic [31:0] r;
    logic [7:0]  f;
    logic        e;
    fp_rnd_model(add_sign_i, add_sub_0_i, add_fract_i, 5'd0, add_shl_i, 10'd0,
                 add_exp_shl_i, add_exp_sh0_i, add_inv_i, add_inf_i, add_snan_i,
                 add_qnan_i, add_nan_sign_i, rmode_i, mask_i, except_en_i, r, f, e);
    res_q.push_back(r);
    flags_q.push_back(f);
    exc_q.push_back(e);
    add_valid_i = 1'b1;
    @(negedge clk);
    add_valid_i = 1'b0;
  endtask

  task automatic issue_mul();
    logic [31:0] r;
    logic [7:0]  f;
    logic        e;
    fp_rnd_model(mul_sign_i, 1'b0, mul_fract_i, mul_shr_i, {4'b0000, mul_shl_i},
                 mul_exp_shr_i, mul_exp_shl_i, mul_exp_sh0_i, mul_inv_i, mul_inf_i,
                 mul_snan_i, mul_qnan_i, mul_nan_sign_i, rmode_i, mask_i, except_en_i,
                 r, f, e);
    res_q.push_back(r);
    flags_q.push_back(f);
    exc_q.push_back(e);
    mul_valid_i = 1'b1;
    @(negedge clk);
    mul_valid_i = 1'b0;
  endtask

  task automatic load_mul_normal();
    logic [31:0] v;
    clear_fields();
    v             = rand_bits(28);
    mul_sign_i    = v[27];
    mul_fract_i   = {v[26], 1'b1, v[25:0]};    // hidden bit set and carry random
    v             = rand_bits(7);
    mul_exp_sh0_i = {3'b000, v[6:0]} + 10'd1;
  endtask

  task automatic load_add_left();
    logic [31:0] v;
    clear_fields();
    v             = rand_bits(31);
    add_sign_i    = v[30];
    add_shl_i     = (v[29:26] == 4'd0) ? 5'd1 : {1'b0, v[29:26]};
    add_fract_i   = {2'b01, v[25:0]} >> add_shl_i;  // shl brings the lead back to bit 26
    v             = rand_bits(7);
    add_exp_shl_i = {3'b000, v[6:0]} + 10'd1;
  endtask

  // right shift with zero exponent ends denormal
  task automatic load_mul_right();
    logic [31:0] v;
    clear_fields();
    v           = rand_bits(32);
    mul_sign_i  = v[31];
    mul_shr_i   = (v[30:26] == 5'd0) ? 5'd1 : v[30:26];
    mul_fract_i = {2'b01, v[25:0]};
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    int          timer;
    logic [31:0] v;
    lfsr        = 32'h40ee_4dec;
    rst         = 1'b1;
    add_valid_i = 1'b0;
    mul_valid_i = 1'b0;
    rmode_i     = 2'd0;
    mask_i      = 8'hff;
    except_en_i = 1'b0;
    clear_fields();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    chk_reset: assert (!valid_o && res_o == '0 && flags_o == '0 && !except_o) else begin
      n_reset_err++;
      $display("[FAIL] %0t outputs not cleared by reset", $time);
    end

    for (int i = 0; i < 6; i++) begin  // back to back with alternating sources
      rmode_i = i[1:0];
      load_add_left();
      issue_add();
      load_mul_normal();
      issue_mul();
    end
    idle(3);

    for (int m = 0; m < 4; m++) begin
      rmode_i = 2'(m);
      for (int i = 0; i < 20; i++) begin
        load_mul_normal();
        issue_mul();
      end
      for (int g = 0; g < 4; g++) begin  // exact ties with guard and sign varied
        clear_fields();
        mul_sign_i    = g[1];
        mul_fract_i   = {2'b01, 22'd0, g[0], 1'b1, 2'b00};
        mul_exp_sh0_i = 10'd100;
        issue_mul();
      end
      clear_fields();
      mul_fract_i   = {1'b0, 24'hffffff, 1'b1, 2'b00};  // round up carries out
      mul_exp_sh0_i = 10'd120;
      issue_mul();
      clear_fields();
      add_sub_0_i = 1'b1;                               // exact zero from subtraction
      add_sign_i  = 1'b1;
      issue_add();
      for (int i = 0; i < 10; i++) begin
        load_mul_right();
        issue_mul();
      end
    end

    // special values in nearest mode
    rmode_i = 2'd0;
    load_mul_normal();
    mul_exp_sh0_i = 10'd300;
    issue_mul();
    clear_fields();
    mul_fract_i   = {1'b0, 24'hffffff, 1'b1, 2'b00};    // rounds past 254
    mul_exp_sh0_i = 10'd254;
    issue_mul();
    load_mul_normal();
    mul_inf_i = 1'b1;
    issue_mul();
    load_mul_normal();
    mul_sign_i     = 1'b0;                              // nan sign differs from sign
    mul_snan_i     = 1'b1;
    mul_nan_sign_i = 1'b1;
    issue_mul();
    load_add_left();
    add_sign_i = 1'b1;                                  // nan sign stays clear
    add_qnan_i = 1'b1;
    issue_add();
    load_add_left();
    add_inv_i = 1'b1;
    issue_add();

    for (int i = 0; i < 16; i++) begin  // mask and exception enable
      v           = rand_bits(12);
      rmode_i     = v[1:0];
      mask_i      = (i < 4) ? 8'h00 : v[9:2];
      except_en_i = v[10];
      load_mul_right();
      mul_inv_i = v[11];
      issue_mul();
    end
    mask_i      = 8'hff;
    except_en_i = 1'b0;

    timer = 0;
    while (res_q.size() != 0 && timer < 10) begin
      @(negedge clk);
      timer++;
    end
    if (res_q.size() != 0) begin
      n_timeout++;
      $display("timed out with %0d results never delivered", res_q.size());
    end
    idle(2);  // no stray valid_o after the last item
    $display("checks %0d, value errors %0d, valid errors %0d, reset errors %0d, timeouts %0d",
             n_checks, n_value_err, n_valid_err, n_reset_err, n_timeout);
    if (n_value_err + n_valid_err + n_reset_err + n_timeout == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
rtl/fp_rnd_pkg.sv
rtl/fp_src_mux.sv
rtl/fp_align.sv
rtl/fp_round.sv
rtl/fp_pack.sv
rtl/fp32_rnd.sv
bench/tb_fp32_rnd.sv

/* rtl/fp32_rnd.sv */
// top level of the fp32 rounding back end, two-stage chain of mux, align, round and pack
`timescale 1ns/1ps

module fp32_rnd (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             add_valid_i,
  input  logic                             add_sign_i,
  input  logic                             add_sub_0_i,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]   add_fract_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]      add_shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     add_exp_shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     add_exp_sh0_i,
  input  logic                             add_inv_i,
  input  logic                             add_inf_i,
  input  logic                             add_snan_i,
  input  logic                             add_qnan_i,
  input  logic                             add_nan_sign_i,
  input  logic                             mul_valid_i,
  input  logic                             mul_sign_i,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]   mul_fract_i,
  input  logic                             mul_shl_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]      mul_shr_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_shr_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_sh0_i,
  input  logic                             mul_inv_i,
  input  logic                             mul_inf_i,
  input  logic                             mul_snan_i,
  input  logic                             mul_qnan_i,
  input  logic                             mul_nan_sign_i,
  input  logic [fp_rnd_pkg::RM_W-1:0]      rmode_i,
  input  logic [fp_rnd_pkg::FLAG_W-1:0]    mask_i,
  input  logic                             except_en_i,
  output logic [fp_rnd_pkg::FP32_W-1:0]    res_o,
  output logic [fp_rnd_pkg::FLAG_W-1:0]    flags_o,
  output logic                             except_o,
  output logic                             valid_o
);

  // source mux to align
  logic                             src_valid;
  logic                             src_sign;
  logic [fp_rnd_pkg::FRACT_W-1:0]   src_fract;
  logic [fp_rnd_pkg::SH_W-1:0]      src_shr;
  logic [fp_rnd_pkg::SH_W-1:0]      src_shl;
  logic [fp_rnd_pkg::EXP_W-1:0]     src_exp;
  logic                             src_inv;
  logic                             src_inf;
  logic                             src_snan;
  logic                             src_qnan;
  logic                             src_nan_sign;
  // stage 1
  logic                             s1_valid;
  logic                             s1_sign;
  logic [fp_rnd_pkg::EXP_W-1:0]     s1_exp;
  logic [fp_rnd_pkg::FRACT_W-4:0]   s1_fract;
  logic                             s1_round;
  logic                             s1_sticky;
  logic                             s1_inv;
  logic                             s1_inf;
  logic                             s1_snan;
  logic                             s1_qnan;
  logic                             s1_nan_sign;
  logic [fp_rnd_pkg::RM_W-1:0]      s1_rmode;
  logic [fp_rnd_pkg::FLAG_W-1:0]    s1_mask;
  logic                             s1_except_en;
  // round to pack
  logic [fp_rnd_pkg::EXP_W-1:0]     rnd_exp;
  logic [23:0]                      rnd_fract;
  logic                             rnd_lost;

  // source ports share their names with the top
  fp_src_mux u_src_mux (
    .*,
    .src_valid_o (src_valid),    .sign_o     (src_sign),     .fract_o (src_fract),
    .shr_o       (src_shr),      .shl_o      (src_shl),      .exp_o   (src_exp),
    .inv_o       (src_inv),      .inf_o      (src_inf),      .snan_o  (src_snan),
    .qnan_o      (src_qnan),     .nan_sign_o (src_nan_sign)
  );

  fp_align u_align (
    .clk           (clk),          .rst           (rst),
    .src_valid_i   (src_valid),    .sign_i        (src_sign),
    .fract_i       (src_fract),    .shr_i         (src_shr),
    .shl_i         (src_shl),      .exp_i         (src_exp),
    .inv_i         (src_inv),      .inf_i         (src_inf),
    .snan_i        (src_snan),     .qnan_i        (src_qnan),
    .nan_sign_i    (src_nan_sign), .rmode_i       (rmode_i),
    .mask_i        (mask_i),       .except_en_i   (except_en_i),
    .s1_valid_o    (s1_valid),     .s1_sign_o     (s1_sign),
    .s1_exp_o      (s1_exp),       .s1_fract_o    (s1_fract),
    .s1_round_o    (s1_round),     .s1_sticky_o   (s1_sticky),
    .s1_inv_o      (s1_inv),       .s1_inf_o      (s1_inf),
    .s1_snan_o     (s1_snan),      .s1_qnan_o     (s1_qnan),
    .s1_nan_sign_o (s1_nan_sign),  .s1_rmode_o    (s1_rmode),
    .s1_mask_o     (s1_mask),      .s1_except_en_o(s1_except_en)
  );

  fp_round u_round (
    .s1_sign_i   (s1_sign),   .s1_exp_i    (s1_exp),    .s1_fract_i  (s1_fract),
    .s1_round_i  (s1_round),  .s1_sticky_i (s1_sticky), .s1_rmode_i  (s1_rmode),
    .rnd_exp_o   (rnd_exp),   .rnd_fract_o (rnd_fract), .lost_o      (rnd_lost)
  );

  fp_pack u_pack (
    .clk           (clk),          .rst         (rst),
    .s1_valid_i    (s1_valid),     .s1_sign_i   (s1_sign),
    .s1_inv_i      (s1_inv),       .s1_inf_i    (s1_inf),
    .s1_snan_i     (s1_snan),      .s1_qnan_i   (s1_qnan),
    .s1_nan_sign_i (s1_nan_sign),  .rnd_exp_i   (rnd_exp),
    .rnd_fract_i   (rnd_fract),    .lost_i      (rnd_lost),
    .mask_i        (s1_mask),      .except_en_i (s1_except_en),
    .res_o         (res_o),        .flags_o     (flags_o),
    .except_o      (except_o),     .valid_o     (valid_o)
  );

endmodule

/* rtl/fp_align.sv */
// fraction alignment, sticky gathering and the stage 1 register
`timescale 1ns/1ps

module fp_align (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              src_valid_i,
  input  logic                              sign_i,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]    fract_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]       shr_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]       shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]      exp_i,
  input  logic                              inv_i,
  input  logic                              inf_i,
  input  logic                              snan_i,
  input  logic                              qnan_i,
  input  logic                              nan_sign_i,
  input  logic [fp_rnd_pkg::RM_W-1:0]       rmode_i,
  input  logic [fp_rnd_pkg::FLAG_W-1:0]     mask_i,
  input  logic                              except_en_i,
  output logic                              s1_valid_o,
  output logic                              s1_sign_o,
  output logic [fp_rnd_pkg::EXP_W-1:0]      s1_exp_o,
  output logic [fp_rnd_pkg::FRACT_W-4:0]    s1_fract_o,   // carry, mantissa, guard at lsb
  output logic                              s1_round_o,
  output logic                              s1_sticky_o,
  output logic                              s1_inv_o,
  output logic                              s1_inf_o,
  output logic                              s1_snan_o,
  output logic                              s1_qnan_o,
  output logic                              s1_nan_sign_o,
  output logic [fp_rnd_pkg::RM_W-1:0]       s1_rmode_o,
  output logic [fp_rnd_pkg::FLAG_W-1:0]     s1_mask_o,
  output logic                              s1_except_en_o
);

  logic [fp_rnd_pkg::FRACT_W-1:0] fract_sh;
  logic                           sticky_r;  // right shift case
  logic                           sticky_l;  // left shift case
  logic                           sticky;

  assign fract_sh = (|shr_i) ? (fract_i >> shr_i) : (fract_i << shl_i);

  // bits 0 .. shr+1 all fall below the round bit
  always_comb begin
    sticky_r = 1'b0;
    for (int i = 0; i < fp_rnd_pkg::FRACT_W; i++) begin
      if (i <= int'(shr_i) + 1)
        sticky_r = sticky_r | fract_i[i];
    end
  end

  always_comb begin
    case (shl_i)
      5'd0:    sticky_l = |fract_i[1:0];
      5'd1:    sticky_l = fract_i[0];
      default: sticky_l = 1'b0;  // low bits move up, nothing lost
    endcase
  end

  assign sticky = (|shr_i) ? sticky_r : sticky_l;

  //////////////////////////////////////////////////
  // stage 1 register

  always_ff @(posedge clk) begin
    if (rst)
      s1_valid_o <= 1'b0;
    else
      s1_valid_o <= src_valid_i;
  end

  always_ff @(posedge clk) begin
    if (src_valid_i) begin
      s1_sign_o      <= sign_i;
      s1_exp_o       <= exp_i;
      s1_fract_o     <= fract_sh[fp_rnd_pkg::FRACT_W-1:3];
      s1_round_o     <= fract_sh[2];
      s1_sticky_o    <= sticky;
      s1_inv_o       <= inv_i;
      s1_inf_o       <= inf_i;
      s1_snan_o      <= snan_i;
      s1_qnan_o      <= qnan_i;
      s1_nan_sign_o  <= nan_sign_i;
      s1_rmode_o     <= rmode_i;      // mode rides with the item
      s1_mask_o      <= mask_i;
      s1_except_en_o <= except_en_i;
    end
  end

endmodule

/* rtl/fp_pack.sv */
// special-case priority, fp32 word packing, status flags and the output register
`timescale 1ns/1ps

module fp_pack (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             s1_valid_i,
  input  logic                             s1_sign_i,
  input  logic                             s1_inv_i,
  input  logic                             s1_inf_i,
  input  logic                             s1_snan_i,
  input  logic                             s1_qnan_i,
  input  logic                             s1_nan_sign_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     rnd_exp_i,
  input  logic [23:0]                      rnd_fract_i,
  input  logic                             lost_i,
  input  logic [fp_rnd_pkg::FLAG_W-1:0]    mask_i,
  input  logic                             except_en_i,
  output logic [fp_rnd_pkg::FP32_W-1:0]    res_o,
  output logic [fp_rnd_pkg::FLAG_W-1:0]    flags_o,
  output logic                             except_o,
  output logic                             valid_o
);

  fp_rnd_pkg::fp32_word_u          word;
  logic                            ovf;
  logic                            unf;
  logic                            zer;
  logic                            ine;
  logic                            inf;
  logic [fp_rnd_pkg::FLAG_W-1:0]   flags_m;  // after mask

  // first match wins
  always_comb begin
    word.raw = '0;
    {ovf, unf, zer, ine, inf} = 5'b0;
    if (s1_snan_i | s1_qnan_i) begin
      word.raw = {s1_nan_sign_i, fp_rnd_pkg::QNAN_BITS};
    end else if (s1_inv_i) begin
      word.raw = {s1_sign_i, fp_rnd_pkg::SNAN_BITS};
    end else if ((rnd_exp_i > fp_rnd_pkg::EXP_MAX_FINITE) | s1_inf_i) begin
      word.raw = {s1_sign_i, fp_rnd_pkg::INF_BITS};
      inf      = 1'b1;
      ovf      = ~s1_inf_i;            // infinite input is no overflow
      ine      = lost_i | ~s1_inf_i;
    end else if (~rnd_fract_i[23]) begin
      word.f.sign  = s1_sign_i;        // denormal or zero
      word.f.exp   = 8'd0;
      word.f.fract = rnd_fract_i[22:0];
      unf          = lost_i;
      zer          = ~|rnd_fract_i;
      ine          = lost_i;
    end else begin
      word.f.sign  = s1_sign_i;        // normal, hidden bit dropped
      word.f.exp   = rnd_exp_i[7:0];
      word.f.fract = rnd_fract_i[22:0];
      ine          = lost_i;
    end
  end

  always_comb begin
    flags_m                          = '0;
    flags_m[fp_rnd_pkg::FLG_OVF]     = ovf;
    flags_m[fp_rnd_pkg::FLG_UNF]     = unf;
    flags_m[fp_rnd_pkg::FLG_SNAN]    = s1_inv_i;
    flags_m[fp_rnd_pkg::FLG_QNAN]    = s1_qnan_i;
    flags_m[fp_rnd_pkg::FLG_ZERO]    = zer;
    flags_m[fp_rnd_pkg::FLG_INEXACT] = ine;
    flags_m[fp_rnd_pkg::FLG_INVALID] = s1_inv_i | s1_snan_i;
    flags_m[fp_rnd_pkg::FLG_INF]     = inf;
    flags_m                          = flags_m & mask_i;
  end

  //////////////////////////////////////////////////
  // stage 2 register, holds between items

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o  <= 1'b0;
      res_o    <= '0;
      flags_o  <= '0;
      except_o <= 1'b0;
    end else begin
      valid_o <= s1_valid_i;  // one cycle strobe
      if (s1_valid_i) begin
        res_o    <= word.raw;
        flags_o  <= flags_m;
        except_o <= except_en_i & (|flags_m);
      end
    end
  end

endmodule

/* rtl/fp_rnd_pkg.sv */
// widths, rounding-mode codes, flag positions, special-value patterns, fp32 word union
package fp_rnd_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int FRACT_W = 28;  // fraction with carry, round and sticky
  localparam int EXP_W   = 10;  // biased exponent, room for ovf/unf
  localparam int SH_W    = 5;
  localparam int RM_W    = 2;
  localparam int FLAG_W  = 8;
  localparam int FP32_W  = 32;

  //////////////////////////////////////////////////
  // rounding modes
  localparam logic [RM_W-1:0] RM_NEAREST = 2'd0;
  localparam logic [RM_W-1:0] RM_TO_ZERO = 2'd1;
  localparam logic [RM_W-1:0] RM_TO_INFP = 2'd2;
  localparam logic [RM_W-1:0] RM_TO_INFM = 2'd3;

  // status flag bit positions
  localparam int FLG_OVF     = 0;
  localparam int FLG_UNF     = 1;
  localparam int FLG_SNAN    = 2;  // snan or invalid indication
  localparam int FLG_QNAN    = 3;
  localparam int FLG_ZERO    = 4;
  localparam int FLG_INEXACT = 5;
  localparam int FLG_INVALID = 6;
  localparam int FLG_INF     = 7;

  localparam logic [EXP_W-1:0] EXP_MAX_FINITE = 10'd254;

  // special values, sign bit excluded
  localparam logic [FP32_W-2:0] INF_BITS  = {8'hff, 23'h000000};
  localparam logic [FP32_W-2:0] QNAN_BITS = {8'hff, 23'h400000};
  localparam logic [FP32_W-2:0] SNAN_BITS = {8'hff, 23'h3fffff};

  //////////////////////////////////////////////////
  // result word, built by fields and sent out raw
  typedef union packed {
    logic [FP32_W-1:0] raw;
    struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] fract;
    } f;
  } fp32_word_u;

endpackage

/* rtl/fp_round.sv */
// rounding decision, increment and carry renormalization
`timescale 1ns/1ps

module fp_round (
  input  logic                            s1_sign_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]    s1_exp_i,
  input  logic [fp_rnd_pkg::FRACT_W-4:0]  s1_fract_i,
  input  logic                            s1_round_i,
  input  logic                            s1_sticky_i,
  input  logic [fp_rnd_pkg::RM_W-1:0]     s1_rmode_i,
  output logic [fp_rnd_pkg::EXP_W-1:0]    rnd_exp_o,
  output logic [23:0]                     rnd_fract_o,
  output logic                            lost_o
);

  logic                           guard;      // mantissa lsb
  logic                           rnd_up;
  logic [fp_rnd_pkg::FRACT_W-4:0] fract_rnd;
  logic                           rnd_carry;  // increment reached bit 24

  assign guard  = s1_fract_i[0];
  assign lost_o = s1_round_i | s1_sticky_i;

  always_comb begin
    case (s1_rmode_i)
      fp_rnd_pkg::RM_NEAREST: rnd_up = s1_round_i & (s1_sticky_i | guard);  // tie to even
      fp_rnd_pkg::RM_TO_INFP: rnd_up = ~s1_sign_i & lost_o;
      fp_rnd_pkg::RM_TO_INFM: rnd_up = s1_sign_i & lost_o;
      default:                rnd_up = 1'b0;  // toward zero, truncate
    endcase
  end

  assign fract_rnd = s1_fract_i + {{(fp_rnd_pkg::FRACT_W-4){1'b0}}, rnd_up};
  assign rnd_carry = fract_rnd[24];

  // renormalize after carry out
  assign rnd_exp_o   = s1_exp_i + {{(fp_rnd_pkg::EXP_W-1){1'b0}}, rnd_carry};
  assign rnd_fract_o = rnd_carry ? fract_rnd[24:1] : fract_rnd[23:0];

endmodule

/* rtl/fp_src_mux.sv */
// source select between adder and multiplier, carry handling, shift and exponent choice
`timescale 1ns/1ps

module fp_src_mux (
  input  logic                             add_valid_i,
  input  logic                             mul_valid_i,
  input  logic                             add_sign_i,
  input  logic                             add_sub_0_i,    // exact zero from subtraction
  input  logic                             mul_sign_i,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]   add_fract_i,
  input  logic [fp_rnd_pkg::FRACT_W-1:0]   mul_fract_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]      add_shl_i,
  input  logic                             mul_shl_i,
  input  logic [fp_rnd_pkg::SH_W-1:0]      mul_shr_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     add_exp_shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     add_exp_sh0_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_shr_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_shl_i,
  input  logic [fp_rnd_pkg::EXP_W-1:0]     mul_exp_sh0_i,
  input  logic                             add_inv_i,
  input  logic                             mul_inv_i,
  input  logic                             add_inf_i,
  input  logic                             mul_inf_i,
  input  logic                             add_snan_i,
  input  logic                             mul_snan_i,
  input  logic                             add_qnan_i,
  input  logic                             mul_qnan_i,
  input  logic                             add_nan_sign_i,
  input  logic                             mul_nan_sign_i,
  input  logic [fp_rnd_pkg::RM_W-1:0]      rmode_i,
  output logic                             src_valid_o,
  output logic                             sign_o,
  output logic [fp_rnd_pkg::FRACT_W-1:0]   fract_o,
  output logic [fp_rnd_pkg::SH_W-1:0]      shr_o,
  output logic [fp_rnd_pkg::SH_W-1:0]      shl_o,
  output logic [fp_rnd_pkg::EXP_W-1:0]     exp_o,
  output logic                             inv_o,
  output logic                             inf_o,
  output logic                             snan_o,
  output logic                             qnan_o,
  output logic                             nan_sign_o
);

  logic                         add_sign;  // zero-sub sign fixed up
  logic                         carry;     // fraction overflowed into bit 27
  logic [fp_rnd_pkg::SH_W-1:0]  shr_req;   // right shift asked by source
  logic [fp_rnd_pkg::EXP_W-1:0] exp_shl;
  logic [fp_rnd_pkg::EXP_W-1:0] exp_sh0;

  // exact zero is -0 only when rounding toward minus infinity
  assign add_sign = add_sub_0_i ? (rmode_i == fp_rnd_pkg::RM_TO_INFM) : add_sign_i;

  assign src_valid_o = add_valid_i | mul_valid_i;

  // strobes are one-hot, so and-or gating
  assign {sign_o, inv_o, inf_o, snan_o, qnan_o, nan_sign_o} =
    ({6{add_valid_i}} & {add_sign, add_inv_i, add_inf_i, add_snan_i, add_qnan_i,
                         add_nan_sign_i}) |
    ({6{mul_valid_i}} & {mul_sign_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i,
                         mul_nan_sign_i});

  assign fract_o = ({fp_rnd_pkg::FRACT_W{add_valid_i}} & add_fract_i) |
                   ({fp_rnd_pkg::FRACT_W{mul_valid_i}} & mul_fract_i);
  assign carry   = fract_o[fp_rnd_pkg::FRACT_W-1];

  // adder never shifts right
  assign shr_req = {fp_rnd_pkg::SH_W{mul_valid_i}} & mul_shr_i;
  assign shl_o   = ({fp_rnd_pkg::SH_W{add_valid_i}} & add_shl_i) |
                   ({fp_rnd_pkg::SH_W{mul_valid_i}} & {{(fp_rnd_pkg::SH_W-1){1'b0}}, mul_shl_i});
  assign shr_o   = (|shr_req) ? shr_req : {{(fp_rnd_pkg::SH_W-1){1'b0}}, carry};

  assign exp_shl = ({fp_rnd_pkg::EXP_W{add_valid_i}} & add_exp_shl_i) |
                   ({fp_rnd_pkg::EXP_W{mul_valid_i}} & mul_exp_shl_i);
  assign exp_sh0 = ({fp_rnd_pkg::EXP_W{add_valid_i}} & add_exp_sh0_i) |
                   ({fp_rnd_pkg::EXP_W{mul_valid_i}} & mul_exp_sh0_i);

  // exponent pick: requested shr, then no shift (+carry), then shl
  assign exp_o = (|shr_req) ? mul_exp_shr_i :
                 (~|shl_o)  ? exp_sh0 + {{(fp_rnd_pkg::EXP_W-1){1'b0}}, carry} :
                              exp_shl;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the fp32 rounding testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f files.f --top-module tb_fp32_rnd -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
! grep -q "Verification failed" sim.log && grep -q "Verification passed" sim.log
